/* Makefile */
# Verilator flow for the 6809-style core testbench

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a failing run ends in $$fatal, which gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/bus_pkg.sv
rtl/cpu_pkg.sv
rtl/irq_sync.sv
rtl/op_decode.sv
rtl/alu8.sv
rtl/reg_file.sv
rtl/sequencer.sv
rtl/cpu_top.sv
dv/tb_clk.sv
dv/cpu_tb.sv

/* dv/cpu_tb.sv */
// ======================================================================
// testbench top: memory model, scenario table, bus checks and watchdog
// ======================================================================
`timescale 1ns/1ps
module cpu_tb;
	localparam int          CLK_PERIOD      = 40;
	localparam int          NUM_ROWS        = 8;
	localparam int          WATCHDOG_CYCLES = NUM_ROWS * 400;
	localparam logic [15:0] STACK_TOP       = 16'h0400;
	localparam logic [15:0] BOOT_ADDR       = 16'h1000;
	localparam logic [15:0] MAIN_ADDR       = 16'h1010;
	localparam logic [15:0] LOOP_ADDR       = 16'h1018;
	localparam logic [15:0] ISR_ADDR        = 16'h1100;
	localparam logic [15:0] RESULT_ADDR     = 16'h0200;
	localparam logic [15:0] MARKER_ADDR     = 16'h0201;
	localparam logic [7:0]  MARKER          = 8'hA5;

	typedef struct packed {
		logic [7:0]   x;
		logic [7:0]   y;
		logic         irq_en;
		logic [7:0]   exp_store;
		cpu_pkg::cc_t exp_cc;
	} scen_t;

	logic                        cpu_clk;
	logic                        k_reset;
	logic                        rst_req = 1'b0;
	logic                        load_en = 1'b0;
	logic                        irq_n   = 1'b1;
	logic [bus_pkg::DATA_W-1:0]  rdata   = 8'h00;
	bus_pkg::bus_req_t           dut_bus;
	cpu_pkg::seq_state_e         dut_state;
	logic [bus_pkg::DATA_W-1:0]  mem [0:65535];
	scen_t                       scenarios [NUM_ROWS];
	scen_t                       cur;
	logic [31:0]                 lfsr_q = 32'h713f;

	tb_clk #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clk0 (
		.rst_req_i(rst_req), .cpu_clk(cpu_clk), .k_reset(k_reset)
	);

	cpu_top #(.STACK_TOP(STACK_TOP), .SYNC_STAGES(2)) dut0 (
		.cpu_clk(cpu_clk), .k_reset(k_reset), .irq_n_i(irq_n),
		.rdata_i(rdata), .bus_o(dut_bus), .state_o(dut_state)
	);

	// program image of the current row over an address-derived fill
	function automatic logic [7:0] image_byte(input logic [15:0] a);
		case (a)
			cpu_pkg::RESET_VEC:         return BOOT_ADDR[15:8];
			cpu_pkg::RESET_VEC + 16'd1: return BOOT_ADDR[7:0];
			cpu_pkg::IRQ_VEC:           return ISR_ADDR[15:8];
			cpu_pkg::IRQ_VEC + 16'd1:   return ISR_ADDR[7:0];
			BOOT_ADDR:                  return cpu_pkg::RTI; // boot frame sets CC
			STACK_TOP:                  return cur.irq_en ? 8'h00 : 8'h10; // frame CC, I in bit 4
			STACK_TOP + 16'd1:          return 8'h00; // frame A
			STACK_TOP + 16'd2:          return MAIN_ADDR[15:8];
			STACK_TOP + 16'd3:          return MAIN_ADDR[7:0];
			MAIN_ADDR:                  return 8'h01; // not a kept opcode
			MAIN_ADDR + 16'd1:          return cpu_pkg::LDA_IMM;
			MAIN_ADDR + 16'd2:          return cur.x;
			MAIN_ADDR + 16'd3:          return cpu_pkg::ADDA_IMM;
			MAIN_ADDR + 16'd4:          return cur.y;
			MAIN_ADDR + 16'd5:          return cpu_pkg::STA_EXT;
			MAIN_ADDR + 16'd6:          return RESULT_ADDR[15:8];
			MAIN_ADDR + 16'd7:          return RESULT_ADDR[7:0];
			LOOP_ADDR:                  return cpu_pkg::JMP_EXT; // jump to self
			LOOP_ADDR + 16'd1:          return LOOP_ADDR[15:8];
			LOOP_ADDR + 16'd2:          return LOOP_ADDR[7:0];
			ISR_ADDR:                   return cpu_pkg::LDA_IMM;
			ISR_ADDR + 16'd1:           return MARKER;
			ISR_ADDR + 16'd2:           return cpu_pkg::STA_EXT;
			ISR_ADDR + 16'd3:           return MARKER_ADDR[15:8];
			ISR_ADDR + 16'd4:           return MARKER_ADDR[7:0];
			ISR_ADDR + 16'd5:           return cpu_pkg::RTI;
			default:                    return a[15:8] ^ a[7:0] ^ 8'h3C;
		endcase
	endfunction

	always @(posedge cpu_clk)
	begin
		if (load_en)
		begin
			for (int i = 0; i < 65536; i++)
				mem[i[15:0]] <= image_byte(i[15:0]);
		end
		else if (dut_bus.we)
			mem[dut_bus.addr] <= dut_bus.wdata;
		if (dut_bus.oe)
			rdata <= mem[dut_bus.addr]; // data valid in the cycle after oe
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[6:0], lfsr_q[0]};
		end
	endtask

	// expected store and flags from LDA #x then ADDA #y
	function automatic scen_t make_row(input logic [7:0] x, input logic [7:0] y,
		input logic irq_en);
		scen_t      row;
		logic [8:0] wide;
		int         ssum;
		wide          = {1'b0, x} + {1'b0, y};
		ssum          = int'($signed(x)) + int'($signed(y));
		row           = '0;
		row.x         = x;
		row.y         = y;
		row.irq_en    = irq_en;
		row.exp_store = wide[7:0];
		row.exp_cc.i  = !irq_en;
		row.exp_cc.n  = wide[7];
		row.exp_cc.z  = (wide[7:0] == 8'h00);
		row.exp_cc.v  = (ssum > 127) || (ssum < -128);
		row.exp_cc.c  = wide[8];
		return row;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run aborted after an error");
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH time=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic next_access(output logic is_wr, output logic [15:0] addr,
		output logic [7:0] data);
		@(negedge cpu_clk);
		while (!dut_bus.oe && !dut_bus.we)
			@(negedge cpu_clk);
		is_wr = dut_bus.we;
		addr  = dut_bus.addr;
		data  = dut_bus.wdata;
	endtask

	task automatic expect_read(input logic [15:0] exp_addr, input string what);
		logic        is_wr;
		logic [15:0] addr;
		logic [7:0]  data;
		next_access(is_wr, addr, data);
		if (is_wr)
			abort_run($sformatf("expected a read for %s, saw a write to %h", what, addr));
		check_val($sformatf("bus_o.addr (%s)", what), addr, exp_addr);
	endtask

	task automatic expect_write(input logic [15:0] exp_addr, input logic [7:0] exp_data,
		input string what);
		logic        is_wr;
		logic [15:0] addr;
		logic [7:0]  data;
		next_access(is_wr, addr, data);
		if (!is_wr)
			abort_run($sformatf("expected a write for %s, saw a read of %h", what, addr));
		check_val($sformatf("bus_o.addr (%s)", what), addr, exp_addr);
		check_val($sformatf("bus_o.wdata (%s)", what), 16'(data), 16'(exp_data));
	endtask

	// reads in between are loop fetches
	task automatic wait_write(input logic [15:0] exp_addr, input logic [7:0] exp_data,
		input string what);
		logic        is_wr;
		logic [15:0] addr;
		logic [7:0]  data;
		is_wr = 1'b0;
		while (!is_wr)
			next_access(is_wr, addr, data);
		check_val($sformatf("bus_o.addr (%s)", what), addr, exp_addr);
		check_val($sformatf("bus_o.wdata (%s)", what), 16'(data), 16'(exp_data));
	endtask

	task automatic reset_core();
		@(posedge cpu_clk);
		rst_req <= 1'b1;
		load_en <= 1'b1; // image written while the core is held
		irq_n   <= 1'b1;
		@(posedge cpu_clk);
		rst_req <= 1'b0;
		load_en <= 1'b0;
		@(negedge cpu_clk);
		check_val("state_o", 16'(dut_state), 16'(cpu_pkg::ST_RESET));
		check_val("bus_o.oe", 16'(dut_bus.oe), 16'd0);
		check_val("bus_o.we", 16'(dut_bus.we), 16'd0);
		while (k_reset)
			@(negedge cpu_clk);
	endtask

	// single-cycle low pulse, held by the pending flag
	task automatic pulse_irq();
		@(posedge cpu_clk);
		irq_n <= 1'b0;
		@(posedge cpu_clk);
		irq_n <= 1'b1;
	endtask

	initial
	begin
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  en_bit;
		logic [15:0] sp;
		int          r;
		scenarios[0] = make_row(8'h7F, 8'h01, 1'b1);
		scenarios[1] = make_row(8'hFF, 8'h01, 1'b1);
		scenarios[2] = make_row(8'h80, 8'h80, 1'b0);
		scenarios[3] = make_row(8'h12, 8'h34, 1'b1);
		for (r = 4; r < NUM_ROWS; r++)
		begin
			draw_bits(8, x);
			draw_bits(8, y);
			draw_bits(1, en_bit);
			scenarios[r] = make_row(x, y, en_bit[0]);
		end
		for (r = 0; r < NUM_ROWS; r++)
		begin
			cur = scenarios[r];
			reset_core();
			expect_read(cpu_pkg::RESET_VEC, "reset vector high");
			expect_read(cpu_pkg::RESET_VEC + 16'd1, "reset vector low");
			expect_read(BOOT_ADDR, "first fetch");
			wait_write(RESULT_ADDR, cur.exp_store, "STA result");
			if (cur.irq_en)
			begin
				sp = STACK_TOP + 16'd4; // S after the boot RTI
				pulse_irq();
				wait_write(sp - 16'd1, LOOP_ADDR[7:0], "push PC low");
				expect_write(sp - 16'd2, LOOP_ADDR[15:8], "push PC high");
				expect_write(sp - 16'd3, cur.exp_store, "push A");
				expect_write(sp - 16'd4, cur.exp_cc, "push CC");
				expect_read(cpu_pkg::IRQ_VEC, "irq vector high");
				expect_read(cpu_pkg::IRQ_VEC + 16'd1, "irq vector low");
				expect_read(ISR_ADDR, "handler fetch");
				wait_write(MARKER_ADDR, MARKER, "handler marker");
				expect_read(ISR_ADDR + 16'd5, "RTI fetch");
				expect_read(sp - 16'd4, "pull CC");
				expect_read(sp - 16'd3, "pull A");
				expect_read(sp - 16'd2, "pull PC high");
				expect_read(sp - 16'd1, "pull PC low");
				expect_read(LOOP_ADDR, "resume at stacked PC");
			end
		end
		$display("TESTS PASSED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge cpu_clk);
		abort_run("watchdog expired, the DUT stopped reaching the expected bus cycles");
	end
endmodule

/* dv/tb_clk.sv */
// ======================================================================
// testbench clock and reset generator, reset restarts on request
// ======================================================================
`timescale 1ns/1ps
module tb_clk #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	input  logic rst_req_i,
	output logic cpu_clk,
	output logic k_reset
);
	int rst_cnt = RESET_CYCLES; // reset held from time zero

	initial
	begin
		cpu_clk = 1'b0;
	end

	always #(PERIOD_NS / 2) cpu_clk = ~cpu_clk;

	always @(posedge cpu_clk)
	begin
		if (rst_req_i)
			rst_cnt <= RESET_CYCLES;
		else if (rst_cnt != 0)
			rst_cnt <= rst_cnt - 1;
	end

	assign k_reset = (rst_cnt != 0);
endmodule

/* rtl/alu8.sv */
// ==================================================================
// 8-bit ALU, load and add with N, Z, V, C flags
// ==================================================================
`timescale 1ns/1ps
module alu8 (
	input  cpu_pkg::alu_op_e           alu_op_i,
	input  logic [bus_pkg::DATA_W-1:0] a_i,
	input  logic [bus_pkg::DATA_W-1:0] b_i,
	input  cpu_pkg::cc_t               cc_i,
	output logic [bus_pkg::DATA_W-1:0] res_o,
	output cpu_pkg::cc_t               cc_o
);
	logic [bus_pkg::DATA_W:0] sum; // carry in msb

	assign sum = {1'b0, a_i} + {1'b0, b_i};

	always_comb
	begin
		res_o = a_i;
		cc_o  = cc_i; // I mask always carried over
		case (alu_op_i)
			cpu_pkg::LOAD:
			begin
				res_o  = b_i;
				cc_o.v = 1'b0; // C untouched
			end
			cpu_pkg::ADD:
			begin
				res_o  = sum[bus_pkg::DATA_W-1:0];
				cc_o.c = sum[bus_pkg::DATA_W];
				// overflow when both inputs share a sign the result lacks
				cc_o.v = (a_i[7] == b_i[7]) && (res_o[7] != a_i[7]);
			end
			default: ;
		endcase
		if (alu_op_i != cpu_pkg::PASS)
		begin
			cc_o.n = res_o[bus_pkg::DATA_W-1];
			cc_o.z = (res_o == '0);
		end
	end
endmodule

/* rtl/bus_pkg.sv */
// ==================================================================
// memory bus widths and request struct
// ==================================================================
package bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// oe and we are single-cycle strobes, never high together
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              oe;
		logic              we;
	} bus_req_t;

endpackage

/* rtl/cpu_pkg.sv */
// ==================================================================
// core definitions: opcodes, instruction classes, ALU operations,
// CC layout, vector addresses and sequencer states
// ==================================================================
package cpu_pkg;

	typedef enum logic [7:0] {
		NOP      = 8'h12,
		LDA_IMM  = 8'h86,
		ADDA_IMM = 8'h8B,
		STA_EXT  = 8'hB7,
		JMP_EXT  = 8'h7E,
		RTI      = 8'h3B
	} opcode_e;

	typedef enum logic [2:0] {NONE, IMM, STORE_EXT, JUMP_EXT, RETURN} op_class_e;

	typedef enum logic [1:0] {LOAD, ADD, PASS} alu_op_e;

	// 6809 bit order, msb first
	typedef struct packed {
		logic e; // unused, stays zero
		logic f; // unused, stays zero
		logic h; // unused
		logic i; // irq mask
		logic n;
		logic z;
		logic v;
		logic c;
	} cc_t;

	localparam logic [15:0] RESET_VEC = 16'hFFFE;
	localparam logic [15:0] IRQ_VEC   = 16'hFFF8;

	typedef enum logic [4:0] {
		ST_RESET, ST_RD_WAIT, ST_VEC_HI, ST_VEC_LO, ST_FETCH, ST_DECODE, ST_DISPATCH,
		ST_IMM_DATA, ST_EXEC, ST_EA_HI, ST_EA_LO, ST_STORE, ST_PUSH_DEC, ST_PUSH_WR,
		ST_IRQ_VEC, ST_PULL_CC, ST_PULL_A, ST_PULL_PCH, ST_PULL_PCL
	} seq_state_e;

endpackage

/* rtl/cpu_top.sv */
// ==================================================================
// core top level, sequencer, datapath and irq input on the bus
// ==================================================================
`timescale 1ns/1ps
module cpu_top #(
	parameter logic [bus_pkg::ADDR_W-1:0] STACK_TOP   = 16'h0400,
	parameter int                         SYNC_STAGES = 2
) (
	input  logic                       cpu_clk,
	input  logic                       k_reset,
	input  logic                       irq_n_i,
	input  logic [bus_pkg::DATA_W-1:0] rdata_i,
	output bus_pkg::bus_req_t          bus_o,
	output cpu_pkg::seq_state_e        state_o
);
	logic                       irq_pend;
	logic                       irq_clr;
	logic [7:0]                 opcode;
	logic [bus_pkg::DATA_W-1:0] opnd;
	cpu_pkg::op_class_e         op_class;
	cpu_pkg::alu_op_e           alu_op;
	logic [bus_pkg::DATA_W-1:0] alu_res;
	cpu_pkg::cc_t               alu_cc;
	logic [bus_pkg::DATA_W-1:0] a, a_d;
	cpu_pkg::cc_t               cc, cc_d;
	logic [bus_pkg::ADDR_W-1:0] s, pc, pc_d;
	logic                       a_we, cc_we, pc_load, pc_inc, s_inc, s_dec;

	irq_sync #(.SYNC_STAGES(SYNC_STAGES)) irq_sync0 (
		.cpu_clk(cpu_clk), .k_reset(k_reset),
		.irq_n_i(irq_n_i), .irq_clr_i(irq_clr), .irq_pend_o(irq_pend)
	);

	op_decode op_decode0 (
		.opcode_i(opcode), .op_class_o(op_class), .alu_op_o(alu_op)
	);

	alu8 alu0 (
		.alu_op_i(alu_op), .a_i(a), .b_i(opnd), .cc_i(cc),
		.res_o(alu_res), .cc_o(alu_cc)
	);

	reg_file #(.STACK_TOP(STACK_TOP)) regs0 (
		.cpu_clk(cpu_clk), .k_reset(k_reset),
		.a_we_i(a_we), .a_d_i(a_d), .cc_we_i(cc_we), .cc_d_i(cc_d),
		.pc_load_i(pc_load), .pc_d_i(pc_d), .pc_inc_i(pc_inc),
		.s_inc_i(s_inc), .s_dec_i(s_dec),
		.a_o(a), .cc_o(cc), .s_o(s), .pc_o(pc)
	);

	sequencer seq0 (
		.cpu_clk(cpu_clk), .k_reset(k_reset), .rdata_i(rdata_i),
		.irq_pend_i(irq_pend), .irq_clr_o(irq_clr),
		.op_class_i(op_class), .alu_op_i(alu_op),
		.alu_res_i(alu_res), .alu_cc_i(alu_cc),
		.a_i(a), .cc_i(cc), .s_i(s), .pc_i(pc),
		.a_we_o(a_we), .a_d_o(a_d), .cc_we_o(cc_we), .cc_d_o(cc_d),
		.pc_load_o(pc_load), .pc_d_o(pc_d), .pc_inc_o(pc_inc),
		.s_inc_o(s_inc), .s_dec_o(s_dec),
		.opcode_o(opcode), .opnd_o(opnd), .bus_o(bus_o), .state_o(state_o)
	);
endmodule

/* rtl/irq_sync.sv */
// ==================================================================
// IRQ line synchronizer with held pending flag
// ==================================================================
`timescale 1ns/1ps
module irq_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic cpu_clk,
	input  logic k_reset,
	input  logic irq_n_i,
	input  logic irq_clr_i,
	output logic irq_pend_o
);
	logic [SYNC_STAGES-1:0] sync_q; // line is active low, idles high

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			sync_q     <= '1;
			irq_pend_o <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], irq_n_i};
			if (irq_clr_i)
				irq_pend_o <= 1'b0; // sets again next cycle if line still low
			else if (!sync_q[SYNC_STAGES-1])
				irq_pend_o <= 1'b1;
		end
	end
endmodule

/* rtl/op_decode.sv */
// ==================================================================
// opcode to instruction class and ALU operation
// ==================================================================
`timescale 1ns/1ps
module op_decode (
	input  logic [7:0]         opcode_i,
	output cpu_pkg::op_class_e op_class_o,
	output cpu_pkg::alu_op_e   alu_op_o
);
	always_comb
	begin
		op_class_o = cpu_pkg::NONE; // unknown opcodes are skipped
		alu_op_o   = cpu_pkg::PASS;
		case (opcode_i)
			cpu_pkg::LDA_IMM:
			begin
				op_class_o = cpu_pkg::IMM;
				alu_op_o   = cpu_pkg::LOAD;
			end
			cpu_pkg::ADDA_IMM:
			begin
				op_class_o = cpu_pkg::IMM;
				alu_op_o   = cpu_pkg::ADD;
			end
			cpu_pkg::STA_EXT:
				op_class_o = cpu_pkg::STORE_EXT;
			cpu_pkg::JMP_EXT:
				op_class_o = cpu_pkg::JUMP_EXT;
			cpu_pkg::RTI:
				op_class_o = cpu_pkg::RETURN;
			default:
				op_class_o = cpu_pkg::NONE; // NOP lands here too
		endcase
	end
endmodule

/* rtl/reg_file.sv */
// ==================================================================
// A, CC, S and PC registers with load, increment and decrement
// ==================================================================
`timescale 1ns/1ps
module reg_file #(
	parameter logic [bus_pkg::ADDR_W-1:0] STACK_TOP = 16'h0400
) (
	input  logic                       cpu_clk,
	input  logic                       k_reset,
	input  logic                       a_we_i,
	input  logic [bus_pkg::DATA_W-1:0] a_d_i,
	input  logic                       cc_we_i,
	input  cpu_pkg::cc_t               cc_d_i,
	input  logic                       pc_load_i,
	input  logic [bus_pkg::ADDR_W-1:0] pc_d_i,
	input  logic                       pc_inc_i,
	input  logic                       s_inc_i,
	input  logic                       s_dec_i,
	output logic [bus_pkg::DATA_W-1:0] a_o,
	output cpu_pkg::cc_t               cc_o,
	output logic [bus_pkg::ADDR_W-1:0] s_o,
	output logic [bus_pkg::ADDR_W-1:0] pc_o
);
	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			a_o  <= '0;
			cc_o <= '{i: 1'b1, default: 1'b0}; // irq masked out of reset
			s_o  <= STACK_TOP;
			pc_o <= '0;
		end
		else
		begin
			if (a_we_i)
				a_o <= a_d_i;
			if (cc_we_i)
				cc_o <= cc_d_i;
			if (pc_load_i)
				pc_o <= pc_d_i; // load wins over increment
			else if (pc_inc_i)
				pc_o <= pc_o + 16'd1;
			if (s_dec_i)
				s_o <= s_o - 16'd1;
			else if (s_inc_i)
				s_o <= s_o + 16'd1;
		end
	end
endmodule

/* rtl/sequencer.sv */
// ==================================================================
// main FSM: vector load, fetch and dispatch, operand reads,
// STA write, JMP, interrupt stacking and RTI pulls
// ==================================================================
`timescale 1ns/1ps
module sequencer (
	input  logic                        cpu_clk,
	input  logic                        k_reset,
	input  logic [bus_pkg::DATA_W-1:0]  rdata_i,
	input  logic                        irq_pend_i,
	output logic                        irq_clr_o,
	input  cpu_pkg::op_class_e          op_class_i,
	input  cpu_pkg::alu_op_e            alu_op_i,
	input  logic [bus_pkg::DATA_W-1:0]  alu_res_i,
	input  cpu_pkg::cc_t                alu_cc_i,
	input  logic [bus_pkg::DATA_W-1:0]  a_i,
	input  cpu_pkg::cc_t                cc_i,
	input  logic [bus_pkg::ADDR_W-1:0]  s_i,
	input  logic [bus_pkg::ADDR_W-1:0]  pc_i,
	output logic                        a_we_o,
	output logic [bus_pkg::DATA_W-1:0]  a_d_o,
	output logic                        cc_we_o,
	output cpu_pkg::cc_t                cc_d_o,
	output logic                        pc_load_o,
	output logic [bus_pkg::ADDR_W-1:0]  pc_d_o,
	output logic                        pc_inc_o,
	output logic                        s_inc_o,
	output logic                        s_dec_o,
	output logic [7:0]                  opcode_o,
	output logic [bus_pkg::DATA_W-1:0]  opnd_o,
	output bus_pkg::bus_req_t           bus_o,
	output cpu_pkg::seq_state_e         state_o
);
	cpu_pkg::seq_state_e        state_q, state_d;
	cpu_pkg::seq_state_e        ret_q, ret_d; // where a read lands after its oe cycle
	logic [1:0]                 slot_q, slot_d; // push slot
	logic                       oe_q, oe_d;
	logic                       we_q, we_d;
	logic [bus_pkg::ADDR_W-1:0] addr_q, addr_d;
	logic [bus_pkg::DATA_W-1:0] wdata_q, wdata_d;
	logic [7:0]                 opcode_q, opcode_d;
	logic [bus_pkg::DATA_W-1:0] opnd_q, opnd_d;
	logic [bus_pkg::ADDR_W-1:0] ea_q, ea_d;

	always_comb
	begin
		state_d   = state_q;
		ret_d     = ret_q;
		slot_d    = slot_q;
		oe_d      = 1'b0;
		we_d      = 1'b0;
		addr_d    = addr_q;
		wdata_d   = wdata_q;
		opcode_d  = opcode_q;
		opnd_d    = opnd_q;
		ea_d      = ea_q;
		a_we_o    = 1'b0;
		a_d_o     = alu_res_i;
		cc_we_o   = 1'b0;
		cc_d_o    = alu_cc_i;
		pc_load_o = 1'b0;
		pc_d_o    = {ea_q[15:8], rdata_i}; // high byte held, low byte on the bus
		pc_inc_o  = 1'b0;
		s_inc_o   = 1'b0;
		s_dec_o   = 1'b0;
		irq_clr_o = 1'b0;
		case (state_q)
			cpu_pkg::ST_RESET:
			begin
				addr_d  = cpu_pkg::RESET_VEC;
				oe_d    = 1'b1;
				state_d = cpu_pkg::ST_VEC_HI;
			end
			cpu_pkg::ST_RD_WAIT:
				state_d = ret_q; // oe cycle, data valid next
			cpu_pkg::ST_VEC_HI:
			begin
				ea_d[15:8] = rdata_i;
				addr_d     = addr_q + 16'd1; // reset or irq vector low byte
				oe_d       = 1'b1;
				state_d    = cpu_pkg::ST_VEC_LO;
			end
			cpu_pkg::ST_VEC_LO, cpu_pkg::ST_PULL_PCL:
			begin
				pc_load_o = 1'b1;
				state_d   = cpu_pkg::ST_FETCH;
			end
			cpu_pkg::ST_FETCH:
				if (irq_pend_i && !cc_i.i)
				begin
					irq_clr_o = 1'b1;
					slot_d    = '0;
					state_d   = cpu_pkg::ST_PUSH_DEC;
				end
				else
				begin
					addr_d   = pc_i;
					oe_d     = 1'b1;
					pc_inc_o = 1'b1;
					state_d  = cpu_pkg::ST_DECODE;
				end
			cpu_pkg::ST_DECODE:
			begin
				opcode_d = rdata_i;
				state_d  = cpu_pkg::ST_DISPATCH;
			end
			cpu_pkg::ST_DISPATCH:
				case (op_class_i)
					cpu_pkg::IMM, cpu_pkg::STORE_EXT, cpu_pkg::JUMP_EXT:
					begin
						addr_d   = pc_i;
						oe_d     = 1'b1;
						pc_inc_o = 1'b1;
						if (op_class_i == cpu_pkg::IMM)
							state_d = cpu_pkg::ST_IMM_DATA;
						else
							state_d = cpu_pkg::ST_EA_HI;
					end
					cpu_pkg::RETURN:
					begin
						addr_d  = s_i;
						oe_d    = 1'b1;
						s_inc_o = 1'b1;
						state_d = cpu_pkg::ST_PULL_CC;
					end
					default:
						state_d = cpu_pkg::ST_FETCH; // NOP and unknown opcodes
				endcase
			cpu_pkg::ST_IMM_DATA:
			begin
				opnd_d  = rdata_i;
				state_d = cpu_pkg::ST_EXEC;
			end
			cpu_pkg::ST_EXEC:
			begin
				a_we_o  = (alu_op_i != cpu_pkg::PASS);
				cc_we_o = (alu_op_i != cpu_pkg::PASS);
				state_d = cpu_pkg::ST_FETCH;
			end
			cpu_pkg::ST_EA_HI:
			begin
				ea_d[15:8] = rdata_i;
				addr_d     = pc_i;
				oe_d       = 1'b1;
				pc_inc_o   = 1'b1;
				state_d    = cpu_pkg::ST_EA_LO;
			end
			cpu_pkg::ST_EA_LO:
			begin
				ea_d[7:0] = rdata_i;
				if (op_class_i == cpu_pkg::JUMP_EXT)
				begin
					pc_load_o = 1'b1;
					state_d   = cpu_pkg::ST_FETCH;
				end
				else
					state_d = cpu_pkg::ST_STORE;
			end
			cpu_pkg::ST_STORE:
			begin
				addr_d  = ea_q;
				wdata_d = a_i;
				we_d    = 1'b1; // strobe overlaps the next fetch setup
				state_d = cpu_pkg::ST_FETCH;
			end
			cpu_pkg::ST_PUSH_DEC:
			begin
				s_dec_o = 1'b1;
				state_d = cpu_pkg::ST_PUSH_WR;
			end
			cpu_pkg::ST_PUSH_WR:
			begin
				case (slot_q) // fixed stacking order
					2'd0: wdata_d = pc_i[7:0];
					2'd1: wdata_d = pc_i[15:8];
					2'd2: wdata_d = a_i;
					default: wdata_d = cc_i;
				endcase
				addr_d = s_i;
				we_d   = 1'b1;
				slot_d = slot_q + 2'd1;
				if (slot_q == 2'd3)
					state_d = cpu_pkg::ST_IRQ_VEC;
				else
					state_d = cpu_pkg::ST_PUSH_DEC;
			end
			cpu_pkg::ST_IRQ_VEC:
			begin
				cc_d_o   = cc_i;
				cc_d_o.i = 1'b1;
				cc_we_o  = 1'b1;
				addr_d   = cpu_pkg::IRQ_VEC;
				oe_d     = 1'b1;
				state_d  = cpu_pkg::ST_VEC_HI;
			end
			cpu_pkg::ST_PULL_CC:
			begin
				cc_d_o   = cpu_pkg::cc_t'(rdata_i);
				cc_d_o.e = 1'b0;
				cc_d_o.f = 1'b0;
				cc_we_o  = 1'b1;
				addr_d   = s_i;
				oe_d     = 1'b1;
				s_inc_o  = 1'b1;
				state_d  = cpu_pkg::ST_PULL_A;
			end
			cpu_pkg::ST_PULL_A:
			begin
				a_d_o   = rdata_i;
				a_we_o  = 1'b1;
				addr_d  = s_i;
				oe_d    = 1'b1;
				s_inc_o = 1'b1;
				state_d = cpu_pkg::ST_PULL_PCH;
			end
			cpu_pkg::ST_PULL_PCH:
			begin
				ea_d[15:8] = rdata_i;
				addr_d     = s_i;
				oe_d       = 1'b1;
				s_inc_o    = 1'b1;
				state_d    = cpu_pkg::ST_PULL_PCL;
			end
			default:
				state_d = cpu_pkg::ST_RESET;
		endcase
		// every read passes through the oe cycle before its data state
		if (oe_d)
		begin
			ret_d   = state_d;
			state_d = cpu_pkg::ST_RD_WAIT;
		end
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state_q <= cpu_pkg::ST_RESET;
			ret_q   <= cpu_pkg::ST_RESET;
			slot_q  <= '0;
			oe_q    <= 1'b0;
			we_q    <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			ret_q   <= ret_d;
			slot_q  <= slot_d;
			oe_q    <= oe_d;
			we_q    <= we_d;
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		addr_q   <= addr_d;
		wdata_q  <= wdata_d;
		opcode_q <= opcode_d;
		opnd_q   <= opnd_d;
		ea_q     <= ea_d;
	end

	assign bus_o    = '{addr: addr_q, wdata: wdata_q, oe: oe_q, we: we_q};
	assign state_o  = state_q;
	assign opcode_o = opcode_q;
	assign opnd_o   = opnd_q;
endmodule
